/* src/codec_init_pkg.sv */
`default_nettype none

package codec_init_pkg;

	// field view, as the codec register map sees it
	typedef struct packed {
		logic [6:0] reg_addr;
		logic [8:0] reg_data;
	} cmd_fields_s;

	// byte view, as the bus sends it
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} cmd_bytes_s;

	typedef union packed {
		cmd_fields_s fields;
		cmd_bytes_s  bytes;
	} codec_cmd_u;

	// forward half of a req/ack link
	typedef struct packed {
		logic       req;
		codec_cmd_u cmd;
	} cmd_link_s;

	localparam logic [6:0] CODEC_ADDR = 7'h1a; // write byte is 8'h34

	localparam int N_CMDS = 7;

	localparam logic [15:0] CMD_TABLE [0:N_CMDS-1] = '{
		16'h1e00, // reset
		16'h0815, // analog path
		16'h0a00, // digital path
		16'h0c00, // power down
		16'h0e42, // digital interface format
		16'h1019, // sampling control
		16'h1201  // active
	};

endpackage

`default_nettype wire

/* src/init_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module init_sequencer (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire                       i_start,
	input  wire                       i_ack,
	output codec_init_pkg::cmd_link_s o_link,
	output logic                      o_last
);

	localparam int IW = $clog2(codec_init_pkg::N_CMDS);
	localparam logic [IW-1:0] LAST_IDX = IW'(codec_init_pkg::N_CMDS - 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOAD,
		S_REQ,
		S_REL
	} state_e;

	state_e                     state_r;
	logic [IW-1:0]              idx_r;
	logic                       req_r;
	codec_init_pkg::codec_cmd_u cmd_r;
	logic [15:0]                entry;

	assign entry = codec_init_pkg::CMD_TABLE[idx_r];

	assign o_link.req = req_r;
	assign o_link.cmd = cmd_r;
	assign o_last     = req_r && (idx_r == LAST_IDX);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= S_IDLE;
			idx_r   <= '0;
			req_r   <= 1'b0;
		end else begin
			case (state_r)
				S_IDLE: begin
					if (i_start) begin // also the state after a finished run
						idx_r   <= '0;
						state_r <= S_LOAD;
					end
				end
				S_LOAD: begin
					req_r   <= 1'b1;
					state_r <= S_REQ;
				end
				S_REQ: begin
					if (i_ack) begin
						req_r   <= 1'b0;
						state_r <= S_REL;
					end
				end
				S_REL: begin
					if (!i_ack) begin // four phases done
						if (idx_r == LAST_IDX) begin
							state_r <= S_IDLE;
						end else begin
							idx_r   <= idx_r + 1'b1;
							state_r <= S_LOAD;
						end
					end
				end
				default: state_r <= S_IDLE;
			endcase
		end
	end

	// table entry split into register fields
	always_ff @(posedge i_clk) begin
		if (state_r == S_LOAD) begin
			cmd_r.fields.reg_addr <= entry[15:9];
			cmd_r.fields.reg_data <= entry[8:0];
		end
	end

endmodule

`default_nettype wire

/* src/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  wire codec_init_pkg::cmd_link_s i_link,
	output logic                      o_ack,
	input  wire                       i_last,
	output codec_init_pkg::cmd_link_s o_link,
	input  wire                       i_ack,
	output logic                      o_last
);

	localparam int AW = $clog2(FIFO_DEPTH);

	codec_init_pkg::codec_cmd_u mem [FIFO_DEPTH];
	logic                       last_mem [FIFO_DEPTH];

	logic [AW:0] wr_ptr, rd_ptr; // extra bit tells full from empty
	logic        full, empty;
	logic        push, pop;
	logic        in_ack_r;
	logic        out_req_r, out_wait_r;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push  = i_link.req && !in_ack_r && !full;
	assign pop   = out_wait_r && !i_ack; // ack fall ends the output phase

	assign o_ack      = in_ack_r;
	assign o_link.req = out_req_r;
	assign o_link.cmd = mem[rd_ptr[AW-1:0]];
	assign o_last     = out_req_r && last_mem[rd_ptr[AW-1:0]];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			in_ack_r   <= 1'b0;
			out_req_r  <= 1'b0;
			out_wait_r <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr   <= wr_ptr + 1'b1;
				in_ack_r <= 1'b1;
			end else if (in_ack_r && !i_link.req) begin
				in_ack_r <= 1'b0;
			end

			if (!out_req_r && !out_wait_r && !empty) begin
				out_req_r <= 1'b1;
			end else if (out_req_r && i_ack) begin
				out_req_r  <= 1'b0;
				out_wait_r <= 1'b1;
			end else if (pop) begin
				out_wait_r <= 1'b0;
				rd_ptr     <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]]      <= i_link.cmd;
			last_mem[wr_ptr[AW-1:0]] <= i_last;
		end
	end

endmodule

`default_nettype wire

/* src/i2c_write_master.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_write_master #(
	parameter int CLK_DIV = 4
) (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire codec_init_pkg::cmd_link_s i_link,
	output logic                           o_ack,
	input  wire                            i_last,
	input  wire                            i_start,
	input  wire                            i_sda,
	output logic                           o_scl,
	output logic                           o_sda_oe,
	output logic                           o_nack,
	output logic                           o_done
);

	localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DW-1:0] DIV_MAX = DW'(CLK_DIV - 1);
	localparam logic [4:0] LAST_BIT = 5'd26;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_BITS,
		S_ACK,
		S_STOP,
		S_HAND
	} state_e;

	state_e      state_r;
	logic [DW-1:0] div_r;
	logic        tick;
	logic [1:0]  q_r; // quarter within a bit time
	logic [4:0]  bit_r;
	logic [4:0]  bit_nx;
	logic        slot_nx;
	logic [26:0] shift_r;
	logic        last_r;
	logic        ack_r;
	logic        nack_r;
	logic        done_r;
	logic        scl_c, oe_c;
	logic        scl_r, oe_r;

	assign tick    = (div_r == DIV_MAX);
	assign bit_nx  = bit_r + 1'b1;
	assign slot_nx = (bit_nx == 5'd8) || (bit_nx == 5'd17) || (bit_nx == LAST_BIT);

	assign o_ack    = ack_r;
	assign o_nack   = nack_r;
	assign o_done   = done_r;
	assign o_scl    = scl_r;
	assign o_sda_oe = oe_r;

	// quarter period divider, held in reset between transactions
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_r <= '0;
		end else if (state_r == S_IDLE || state_r == S_HAND || tick) begin
			div_r <= '0;
		end else begin
			div_r <= div_r + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= S_IDLE;
			q_r     <= '0;
			bit_r   <= '0;
			last_r  <= 1'b0;
			ack_r   <= 1'b0;
			nack_r  <= 1'b0;
			done_r  <= 1'b0;
		end else begin
			if (i_start && done_r) begin // new run, a start mid-run is ignored
				done_r <= 1'b0;
				nack_r <= 1'b0;
			end
			case (state_r)
				S_IDLE: begin
					if (i_link.req) begin
						last_r  <= i_last;
						q_r     <= '0;
						bit_r   <= '0;
						state_r <= S_START;
					end
				end
				S_START: begin
					if (tick) begin
						q_r <= q_r + 1'b1;
						if (q_r == 2'd3) begin
							state_r <= S_BITS;
						end
					end
				end
				S_BITS, S_ACK: begin
					if (tick) begin
						q_r <= q_r + 1'b1;
						if (state_r == S_ACK && q_r == 2'd2 && i_sda) begin
							nack_r <= 1'b1; // sticky
						end
						if (q_r == 2'd3) begin
							bit_r <= bit_nx;
							if (bit_r == LAST_BIT) begin
								state_r <= S_STOP;
							end else if (slot_nx) begin
								state_r <= S_ACK;
							end else begin
								state_r <= S_BITS;
							end
						end
					end
				end
				S_STOP: begin
					if (tick) begin
						q_r <= q_r + 1'b1;
						if (q_r == 2'd3) begin
							ack_r   <= 1'b1;
							state_r <= S_HAND;
							if (last_r) begin
								done_r <= 1'b1;
							end
						end
					end
				end
				S_HAND: begin
					if (!i_link.req) begin
						ack_r   <= 1'b0;
						state_r <= S_IDLE;
					end
				end
				default: state_r <= S_IDLE;
			endcase
		end
	end

	// address byte, write bit, then both data bytes, ones fill the ack slots
	always_ff @(posedge i_clk) begin
		if (state_r == S_IDLE && i_link.req) begin
			shift_r <= {codec_init_pkg::CODEC_ADDR, 1'b0, 1'b1,
				i_link.cmd.bytes.hi, 1'b1, i_link.cmd.bytes.lo, 1'b1};
		end else if (state_r == S_BITS || state_r == S_ACK) begin
			if (tick && q_r == 2'd3) begin
				shift_r <= {shift_r[25:0], 1'b1};
			end
		end
	end

	always_comb begin
		scl_c = 1'b1;
		oe_c  = 1'b0;
		case (state_r)
			S_START: begin
				scl_c = (q_r != 2'd3);
				oe_c  = (q_r != 2'd0); // sda falls with scl high
			end
			S_BITS: begin
				scl_c = q_r[0] ^ q_r[1];
				oe_c  = ~shift_r[26];
			end
			S_ACK: begin
				scl_c = q_r[0] ^ q_r[1];
			end
			S_STOP: begin
				scl_c = (q_r != 2'd0);
				oe_c  = ~q_r[1]; // sda rises with scl high
			end
			default: begin
			end
		endcase
	end

	// registered pins keep scl glitch free
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			scl_r <= 1'b1;
			oe_r  <= 1'b0;
		end else begin
			scl_r <= scl_c;
			oe_r  <= oe_c;
		end
	end

endmodule

`default_nettype wire

/* src/codec_init_top.sv */
`timescale 1ns/1ps
`default_nettype none

module codec_init_top #(
	parameter int CLK_DIV    = 4,
	parameter int FIFO_DEPTH = 4
) (
	input  wire i_clk,
	input  wire i_rst_n,
	input  wire i_start,
	input  wire i_sda,
	output wire o_scl,
	output wire o_sda_oe, // high pulls sda low
	output wire o_done,
	output wire o_nack
);

	codec_init_pkg::cmd_link_s seq_link;
	codec_init_pkg::cmd_link_s mst_link;
	logic                      seq_ack;
	logic                      mst_ack;
	logic                      seq_last;
	logic                      mst_last;

	init_sequencer u_seq (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_start (i_start),
		.i_ack   (seq_ack),
		.o_link  (seq_link),
		.o_last  (seq_last)
	);

	cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_link  (seq_link),
		.o_ack   (seq_ack),
		.i_last  (seq_last),
		.o_link  (mst_link),
		.i_ack   (mst_ack),
		.o_last  (mst_last)
	);

	i2c_write_master #(
		.CLK_DIV (CLK_DIV)
	) u_mst (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_link   (mst_link),
		.o_ack    (mst_ack),
		.i_last   (mst_last),
		.i_start  (i_start),
		.i_sda    (i_sda),
		.o_scl    (o_scl),
		.o_sda_oe (o_sda_oe),
		.o_nack   (o_nack),
		.o_done   (o_done)
	);

endmodule

`default_nettype wire

/* tb/tb_codec_init.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_codec_init #(
	parameter int CLK_DIV    = 2,
	parameter int FIFO_DEPTH = 4
);

	localparam string      STIM_FILE = "tb/codec_init_stimulus.txt";
	localparam int         N_WORDS   = 7; // commands per run
	localparam int         GAP_MAX   = 48;
	localparam logic [7:0] ADDR_BYTE = {codec_init_pkg::CODEC_ADDR, 1'b0}; // write bit low

	logic clk;
	logic rst_n;
	logic start;
	wire  scl;
	wire  sda_oe;
	wire  done;
	wire  nack;
	wire  sda_line;
	logic sda_pull = 1'b0; // target holds sda low

	logic [6:0]  mask_q [$];
	logic [15:0] word_q [$];
	int          n_runs     = 0;
	logic        loaded     = 1'b0;
	int          cur_run    = 0;
	int          run_base   = 0;
	int          txn_total  = 0;
	int          mon_errors = 0;
	int          seq_errors = 0;
	logic [31:0] rnd        = 32'hffca_647a;

	// bus target state
	logic        scl_prev = 1'b1;
	logic        sda_prev = 1'b1;
	logic        in_txn   = 1'b0;
	int          bit_cnt  = 0;
	logic [23:0] frame    = '0;

	assign sda_line = (sda_oe || sda_pull) ? 1'b0 : 1'b1; // pull-up

	codec_init_top #(
		.CLK_DIV    (CLK_DIV),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_dut (
		.i_clk    (clk),
		.i_rst_n  (rst_n),
		.i_start  (start),
		.i_sda    (sda_line),
		.o_scl    (scl),
		.o_sda_oe (sda_oe),
		.o_done   (done),
		.o_nack   (nack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// eight data bits, then the acknowledge bit
	function automatic logic is_ack_slot(input int n);
		return (n % 9) == 8;
	endfunction

	function automatic logic nack_planned(input int run, input int idx);
		logic [6:0] m;
		m = mask_q[run];
		return ((m >> idx) & 7'd1) != 7'd0;
	endfunction

	task automatic load_stimulus();
		int               fd;
		int               code;
		logic [8*128-1:0] line;
		logic [31:0]      m;
		logic [31:0]      w [7];
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			seq_errors = seq_errors + 1;
			$display("cannot open %s", STIM_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				code = $fgets(line, fd);
				if (code > 0) begin // comment lines match nothing
					code = $sscanf(line, "%h %h %h %h %h %h %h %h",
						m, w[0], w[1], w[2], w[3], w[4], w[5], w[6]);
					if (code == 8) begin
						mask_q.push_back(m[6:0]);
						for (int i = 0; i < N_WORDS; i++) begin
							word_q.push_back(w[i][15:0]);
						end
					end else if (code > 0) begin
						seq_errors = seq_errors + 1;
						$display("stimulus line with %0d fields instead of 8", code);
					end
				end
			end
			$fclose(fd);
		end
		n_runs = mask_q.size();
	endtask

	// codec target, sampled on the system clock
	always @(posedge clk) begin
		logic        scl_now;
		logic        sda_now;
		int          idx;
		logic [15:0] exp_word;
		scl_now = scl;
		sda_now = sda_line;
		idx     = txn_total - run_base;
		if (rst_n) begin
			if (scl_prev && scl_now && sda_prev && !sda_now) begin // start
				assert (!in_txn) else begin
					mon_errors = mon_errors + 1;
					$display("start condition inside a transaction after %0d bits", bit_cnt);
				end
				in_txn  = 1'b1;
				bit_cnt = 0;
				frame   = '0;
			end else if (scl_prev && scl_now && !sda_prev && sda_now) begin // stop
				assert (in_txn && bit_cnt == 28) else begin
					mon_errors = mon_errors + 1;
					$display("stop condition after %0d clock pulses, not after a whole frame",
						bit_cnt);
				end
				if (in_txn && bit_cnt == 28) begin
					txn_total = txn_total + 1;
					assert (frame[23:16] == ADDR_BYTE) else begin
						mon_errors = mon_errors + 1;
						$display("[ERROR] address byte: got 0x%02h expected 0x%02h",
							frame[23:16], ADDR_BYTE);
					end
					assert (idx < N_WORDS) else begin
						mon_errors = mon_errors + 1;
						$display("run %0d has more than seven transactions", cur_run);
					end
					if (idx < N_WORDS) begin
						exp_word = word_q[cur_run * N_WORDS + idx];
						assert (frame[15:0] == exp_word) else begin
							mon_errors = mon_errors + 1;
							$display("[ERROR] command word %0d of run %0d: got 0x%04h expected 0x%04h",
								idx, cur_run, frame[15:0], exp_word);
						end
					end
				end
				in_txn = 1'b0;
			end else if (!scl_prev && scl_now) begin
				assert (in_txn) else begin
					mon_errors = mon_errors + 1;
					$display("clock pulse on the bus with no start condition");
				end
				if (bit_cnt < 27 && !is_ack_slot(bit_cnt)) begin
					frame = {frame[22:0], sda_now};
				end
				bit_cnt = bit_cnt + 1; // pulse 28 belongs to the stop
			end else if (scl_prev && !scl_now && in_txn) begin
				if (bit_cnt < 27 && is_ack_slot(bit_cnt)) begin
					sda_pull <= !nack_planned(cur_run, idx);
				end else begin
					sda_pull <= 1'b0;
				end
			end
		end
		scl_prev = scl_now;
		sda_prev = sda_now;
	end

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic run_sequence(input int r);
		int         delay;
		int         count;
		logic [6:0] mask;
		mask     = mask_q[r];
		cur_run  = r;
		run_base = txn_total;
		pulse_start();
		@(posedge clk);
		assert (done == 1'b0 && nack == 1'b0) else begin
			seq_errors = seq_errors + 1;
			$display("run %0d: start did not clear done and nack", r);
		end
		rnd   = next_rand(rnd);
		delay = 3 + int'(rnd % 32'd16);
		repeat (delay) @(posedge clk);
		pulse_start(); // sequencer still busy, must be ignored
		while (done !== 1'b1) begin
			@(posedge clk);
		end
		count = txn_total - run_base;
		assert (count == N_WORDS) else begin
			seq_errors = seq_errors + 1;
			$display("[ERROR] transaction count at o_done: got 0x%0h expected 0x%0h",
				count, N_WORDS);
		end
		assert (nack == (mask != 7'd0)) else begin
			seq_errors = seq_errors + 1;
			$display("[ERROR] o_nack: got 0x%0h expected 0x%0h (mask 0x%02h)",
				nack, mask != 7'd0, mask);
		end
		rnd   = next_rand(rnd);
		delay = 8 + int'(rnd % 32'd48);
		repeat (delay) @(posedge clk);
		assert (txn_total - run_base == N_WORDS && !in_txn) else begin
			seq_errors = seq_errors + 1;
			$display("run %0d: bus activity after o_done", r);
		end
	endtask

	// watchdog
	initial begin
		int limit;
		wait (loaded);
		limit = n_runs * N_WORDS * 40 * 4 * CLK_DIV + n_runs * (GAP_MAX + 64) + 1000;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);
		for (int r = 0; r < n_runs; r++) begin
			run_sequence(r);
		end
		repeat (8) @(posedge clk);
		$display("runs %0d, transactions %0d, bus errors %0d, run errors %0d",
			n_runs, txn_total, mon_errors, seq_errors);
		if (mon_errors == 0 && seq_errors == 0 && n_runs > 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/codec_init_stimulus.txt */
# columns: nack mask (hex, bit k refuses the acknowledges of command k),
# then the seven command words expected on the bus, in order (hex)
00 1e00 0815 0a00 0c00 0e42 1019 1201
01 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
40 1e00 0815 0a00 0c00 0e42 1019 1201
7f 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
12 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
08 1e00 0815 0a00 0c00 0e42 1019 1201
55 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
2a 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
04 1e00 0815 0a00 0c00 0e42 1019 1201
7f 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
3c 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
20 1e00 0815 0a00 0c00 0e42 1019 1201
02 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201
00 1e00 0815 0a00 0c00 0e42 1019 1201

/* Makefile */
# Verilator build and run of the codec init testbench

VERILATOR  ?= verilator
TOP        ?= tb_codec_init
RTL_TOP    ?= codec_init_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
CLK_DIV    ?= 2
FIFO_DEPTH ?= 4
VFLAGS     ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GCLK_DIV=$(CLK_DIV) \
		-GFIFO_DEPTH=$(FIFO_DEPTH) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Everything OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src.f */
src/codec_init_pkg.sv
src/init_sequencer.sv
src/cmd_fifo.sv
src/i2c_write_master.sv
src/codec_init_top.sv
tb/tb_codec_init.sv
